/* multPkg.sv */
// Shared widths and controller states for the 8x8 shift-and-add multiplier
// Operands are two's complement; the product is 16 bits plus a sign bit in X
`default_nettype none

package multPkg;

    // Operand width of A, B and the switch value S
    localparam int dataWidth = 8;

    // One add/shift pair per multiplier bit
    localparam int numBits = dataWidth;

    // Flops in each input synchronizer chain
    localparam int syncStages = 2;

    // Controller sequence
    typedef enum logic [2:0] {
        Idle,       // Waiting for a button
        ClearLoad,  // Clear A and X, load B from switches
        Start,      // Clear A and X before a run
        AddStep,    // Add or subtract S when M is set
        ShiftStep,  // Arithmetic shift of X:A:B
        Hold        // Wait for both buttons released
    } ctrlState;

endpackage

`default_nettype wire

/* inputSync.sv */
// Multi-flop synchronizer for one asynchronous bit, no reset
// Latency is syncStages clock cycles; intended for slow button and switch levels
`timescale 1ns/100ps
`default_nettype none

module inputSync
    import multPkg::*;
(
    input  wire logic Clk,
    input  wire logic d,  // Asynchronous level from the board
    output logic      q   // Synchronized copy
);

    logic [syncStages-1:0] chain;  // chain[0] may go metastable

    // First flop samples the pin, later flops settle it
    always_ff @(posedge Clk) begin
        chain <= {chain[syncStages-2:0], d};
    end

    assign q = chain[syncStages-1];

endmodule

`default_nettype wire

/* shiftReg8.sv */
// Operand register with clear, parallel load and right shift
// Priority is reset/clear, then load, then shift; serial data enters at the top bit
`timescale 1ns/100ps
`default_nettype none

module shiftReg8
    import multPkg::*;
(
    input  wire logic                 Clk,
    input  wire logic                 reset,
    input  wire logic                 clear,     // Synchronous clear, same as reset
    input  wire logic                 load,      // Parallel load from d
    input  wire logic                 shiftEn,   // Shift right by one
    input  wire logic                 shiftIn,   // Bit entering the MSB on shift
    input  wire logic [dataWidth-1:0] d,
    output logic                      shiftOut,  // Bit leaving the LSB
    output logic [dataWidth-1:0]      q
);

    always_ff @(posedge Clk) begin
        if (reset || clear) begin
            q <= '0;
        end
        else if (load) begin
            q <= d;
        end
        else if (shiftEn) begin
            q <= {shiftIn, q[dataWidth-1:1]};  // Right shift, new bit on top
        end
    end

    // LSB is what falls out on the next shift
    assign shiftOut = q[0];

endmodule

`default_nettype wire

/* addSub9.sv */
// Sign-extended adder/subtractor one bit wider than the operands
// Passes A through unchanged when the multiplier bit is 0
// No overflow flag; the extra bit is enough for one add of two 8-bit values
`timescale 1ns/100ps
`default_nettype none

module addSub9
    import multPkg::*;
(
    input  wire logic [dataWidth-1:0] a,         // Accumulator
    input  wire logic [dataWidth-1:0] s,         // Switch operand
    input  wire logic                 m,         // Current multiplier bit
    input  wire logic                 subtract,  // High on the sign bit step
    output logic [dataWidth-1:0]      sum,
    output logic                      sumX       // Ninth bit, goes to X
);

    logic [dataWidth:0] aExt;     // a with its sign bit repeated
    logic [dataWidth:0] sExt;     // s with its sign bit repeated
    logic [dataWidth:0] operand;  // sExt or its negation
    logic [dataWidth:0] result;

    assign aExt = {a[dataWidth-1], a};
    assign sExt = {s[dataWidth-1], s};

    always_comb begin
        // Two's complement negate for the sign bit of the multiplier
        operand = subtract ? (~sExt + 1'b1) : sExt;
        if (m) begin
            result = aExt + operand;
        end
        else begin
            result = aExt;  // Nothing to add for a zero bit
        end
    end

    assign sum  = result[dataWidth-1:0];
    assign sumX = result[dataWidth];

endmodule

`default_nettype wire

/* multControl.sv */
// Sequencer for clear-load and the signed shift-and-add multiply
// Buttons must already be synchronized and active high
// A run is one Start cycle and numBits add/shift pairs, then waits for release
`timescale 1ns/100ps
`default_nettype none

module multControl
    import multPkg::*;
(
    input  wire logic Clk,
    input  wire logic reset,
    input  wire logic run,        // Run button, synchronized
    input  wire logic clearLoad,  // Clear-load button, synchronized
    input  wire logic m,          // LSB of B
    output logic      shiftEn,
    output logic      ldA,
    output logic      ldB,
    output logic      clearA,
    output logic      subtract
);

    ctrlState state;
    ctrlState nextState;

    logic [$clog2(numBits)-1:0] step;  // Which multiplier bit is being handled
    logic                       lastStep;

    // Last pair handles the sign bit of B
    assign lastStep = (step == ($clog2(numBits))'(numBits - 1));

    always_ff @(posedge Clk) begin
        if (reset) begin
            state <= Idle;
            step  <= '0;
        end
        else begin
            state <= nextState;
            if (state == Start) begin
                step <= '0;
            end
            else if (state == ShiftStep) begin
                step <= step + 1'b1;  // Advance after each shift
            end
        end
    end

    // Next state
    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (clearLoad) begin
                    nextState = ClearLoad;  // Clear-load wins over Run
                end
                else if (run) begin
                    nextState = Start;
                end
            end
            ClearLoad: nextState = Hold;
            Start:     nextState = AddStep;
            AddStep:   nextState = ShiftStep;
            ShiftStep: begin
                if (lastStep) begin
                    nextState = Hold;
                end
                else begin
                    nextState = AddStep;
                end
            end
            Hold: begin
                // Stay until both buttons are up, one run per press
                if (!run && !clearLoad) begin
                    nextState = Idle;
                end
            end
            default: nextState = Idle;
        endcase
    end

    // Control lines are single-cycle levels decoded from the state
    always_comb begin
        shiftEn  = 1'b0;
        ldA      = 1'b0;
        ldB      = 1'b0;
        clearA   = 1'b0;
        subtract = 1'b0;
        case (state)
            ClearLoad: begin
                clearA = 1'b1;
                ldB    = 1'b1;  // B takes the switch value
            end
            Start:     clearA = 1'b1;  // Fresh accumulator, B is kept
            AddStep: begin
                ldA      = m;         // Only load A for a set bit
                subtract = lastStep;  // Sign bit weighs -2^7
            end
            ShiftStep: shiftEn = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hexDriver.sv */
// Nibble to seven-segment decoder, combinational
// Output is active low in gfedcba order, as on the board displays
`timescale 1ns/100ps
`default_nettype none

module hexDriver (
    input  wire logic [3:0] nibble,
    output logic      [6:0] segments  // {g, f, e, d, c, b, a}, 0 lights
);

    always_comb begin
        case (nibble)
            4'h0: segments = 7'b1000000;
            4'h1: segments = 7'b1111001;
            4'h2: segments = 7'b0100100;
            4'h3: segments = 7'b0110000;
            4'h4: segments = 7'b0011001;
            4'h5: segments = 7'b0010010;
            4'h6: segments = 7'b0000010;
            4'h7: segments = 7'b1111000;
            4'h8: segments = 7'b0000000;
            4'h9: segments = 7'b0010000;
            4'hA: segments = 7'b0001000;
            4'hB: segments = 7'b0000011;  // Lower case b
            4'hC: segments = 7'b1000110;
            4'hD: segments = 7'b0100001;  // Lower case d
            4'hE: segments = 7'b0000110;
            4'hF: segments = 7'b0001110;
            default: segments = 7'b1111111;  // Blank
        endcase
    end

endmodule

`default_nettype wire

/* multiplier8x8.sv */
// Signed 8x8 shift-and-add multiplier for the lab board
// Run and clear-load pins are active low; reset is synchronous and not synchronized
// Product is X:A:B after a run; hex digits and Xval lag the registers by one cycle
`timescale 1ns/100ps
`default_nettype none

module multiplier8x8
    import multPkg::*;
(
    input  wire logic                 Clk,
    input  wire logic                 reset,
    input  wire logic                 runN,        // Run button, low when pressed
    input  wire logic                 clearLoadN,  // Clear-load button, low when pressed
    input  wire logic [dataWidth-1:0] S,           // Switches
    output logic      [dataWidth-1:0] Aval,        // High byte of the product
    output logic      [dataWidth-1:0] Bval,        // Low byte of the product
    output logic      [6:0]           AHexU,
    output logic      [6:0]           AHexL,
    output logic      [6:0]           BHexU,
    output logic      [6:0]           BHexL,
    output logic                      Xval         // Sign of the product
);

    // Button levels, active high
    logic runH;
    logic clearLoadH;
    logic runSync;
    logic clearLoadSync;

    logic [dataWidth-1:0] sHold;  // Synchronized switch value

    // Controller outputs
    logic shiftEn;
    logic ldA;
    logic ldB;
    logic clearA;
    logic subtract;

    logic [dataWidth-1:0] aReg;
    logic [dataWidth-1:0] bReg;
    logic                 xReg;   // Sign extension of A
    logic                 aToB;   // A LSB shifting into B MSB
    logic                 M;      // Current multiplier bit
    logic [dataWidth-1:0] sumA;
    logic                 sumX;

    logic [6:0] aHexUComb;
    logic [6:0] aHexLComb;
    logic [6:0] bHexUComb;
    logic [6:0] bHexLComb;

    assign runH       = ~runN;
    assign clearLoadH = ~clearLoadN;

    inputSync buttonSync [1:0] (
        .Clk (Clk),
        .d   ({clearLoadH, runH}),
        .q   ({clearLoadSync, runSync})
    );

    inputSync switchSync [dataWidth-1:0] (
        .Clk (Clk),
        .d   (S),
        .q   (sHold)
    );

    multControl control (
        .Clk       (Clk),
        .reset     (reset),
        .run       (runSync),
        .clearLoad (clearLoadSync),
        .m         (M),
        .shiftEn   (shiftEn),
        .ldA       (ldA),
        .ldB       (ldB),
        .clearA    (clearA),
        .subtract  (subtract)
    );

    // A takes the adder sum; X feeds its top bit on shift
    shiftReg8 regA (
        .Clk      (Clk),
        .reset    (reset),
        .clear    (clearA),
        .load     (ldA),
        .shiftEn  (shiftEn),
        .shiftIn  (xReg),
        .d        (sumA),
        .shiftOut (aToB),
        .q        (aReg)
    );

    // B is only loaded from the switches, never cleared by a run
    shiftReg8 regB (
        .Clk      (Clk),
        .reset    (reset),
        .clear    (1'b0),
        .load     (ldB),
        .shiftEn  (shiftEn),
        .shiftIn  (aToB),
        .d        (sHold),
        .shiftOut (M),
        .q        (bReg)
    );

    addSub9 adder (
        .a        (aReg),
        .s        (sHold),
        .m        (M),
        .subtract (subtract),
        .sum      (sumA),
        .sumX     (sumX)
    );

    // X keeps its value on shift, which makes the shift arithmetic
    always_ff @(posedge Clk) begin
        if (reset || clearA) begin
            xReg <= 1'b0;
        end
        else if (ldA) begin
            xReg <= sumX;
        end
    end

    hexDriver aHexUpper (.nibble(aReg[7:4]), .segments(aHexUComb));
    hexDriver aHexLower (.nibble(aReg[3:0]), .segments(aHexLComb));
    hexDriver bHexUpper (.nibble(bReg[7:4]), .segments(bHexUComb));
    hexDriver bHexLower (.nibble(bReg[3:0]), .segments(bHexLComb));

    // Display outputs registered to keep the decoders off the pin path
    always_ff @(posedge Clk) begin
        AHexU <= aHexUComb;
        AHexL <= aHexLComb;
        BHexU <= bHexUComb;
        BHexL <= bHexLComb;
        Xval  <= xReg;
    end

    assign Aval = aReg;
    assign Bval = bReg;

endmodule

`default_nettype wire

/* multiplier8x8_tb.sv */
// Self-checking testbench for the signed 8x8 multiplier
// Button presses have a fixed length that covers the sync delay and a full run
// Expected products come from a plain signed multiply, not from the add/shift sequence
`timescale 1ns/100ps
`default_nettype none

module multiplier8x8_tb
    import multPkg::*;
();

    localparam int pressLow  = 5;   // Cycles a button is held down
    localparam int pressWait = 30;  // Cycles after release
    localparam int holdLow   = 60;  // Run held far past one sequence
    localparam int numRandom = 40;
    localparam int runCycles = syncStages + 2 * numBits + 2;  // Sync, Start, pairs, Hold exit
    localparam int pressBudget = runCycles + 40;             // 60 cycles per press
    // Clear-load test and its setup multiply, corner and random pairs, chain, hold
    localparam int numPresses = 1 + 2 + 2 * 25 + 2 * numRandom + 4 + 2;
    localparam int timeoutCycles = numPresses * pressBudget + 100;

    logic                 Clk;
    logic                 reset;
    logic                 runN;
    logic                 clearLoadN;
    logic [dataWidth-1:0] S;
    logic [dataWidth-1:0] Aval;
    logic [dataWidth-1:0] Bval;
    logic [6:0]           AHexU;
    logic [6:0]           AHexL;
    logic [6:0]           BHexU;
    logic [6:0]           BHexL;
    logic                 Xval;

    string                testName;      // Handed to the compare process
    logic [dataWidth-1:0] expA;
    logic [dataWidth-1:0] expB;
    logic                 expX;
    logic                 checkPending;
    event                 checkReq;
    int                   testCount;
    int                   failCount;
    logic [31:0]          rngState;
    logic [dataWidth-1:0] corners [5];

    multiplier8x8 u_multiplier8x8 (
        .Clk        (Clk),
        .reset      (reset),
        .runN       (runN),
        .clearLoadN (clearLoadN),
        .S          (S),
        .Aval       (Aval),
        .Bval       (Bval),
        .AHexU      (AHexU),
        .AHexL      (AHexL),
        .BHexU      (BHexU),
        .BHexL      (BHexL),
        .Xval       (Xval)
    );

    always #50 Clk = ~Clk;  // 100 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Signed product with its sign bit on top, as X:A:B should hold it
    function automatic logic [16:0] refProduct(input logic [7:0] b, input logic [7:0] s);
        logic signed [15:0] p;
        p = 16'($signed(b)) * 16'($signed(s));
        return {p[15], p};
    endfunction

    // Active-low gfedcba patterns of the board displays
    function automatic logic [6:0] refSegments(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'hA: return 7'b0001000;
            4'hB: return 7'b0000011;
            4'hC: return 7'b1000110;
            4'hD: return 7'b0100001;
            4'hE: return 7'b0000110;
            default: return 7'b0001110;  // F
        endcase
    endfunction

    task automatic pressClearLoad(input logic [7:0] value);
        @(posedge Clk);
        S          <= value;  // Switches sync as fast as the button
        clearLoadN <= 1'b0;
        repeat (pressLow) @(posedge Clk);
        clearLoadN <= 1'b1;
        repeat (pressWait) @(posedge Clk);
    endtask

    task automatic pressRun(input logic [7:0] value, input int lowCycles);
        @(posedge Clk);
        S    <= value;
        runN <= 1'b0;
        repeat (lowCycles) @(posedge Clk);
        runN <= 1'b1;
        repeat (pressWait) @(posedge Clk);
    endtask

    // Outputs are sampled on the falling edge, away from register updates
    task automatic expectAndCheck(input string name, input logic [16:0] xab);
        @(negedge Clk);
        testName     = name;
        expX         = xab[16];
        expA         = xab[15:8];
        expB         = xab[7:0];
        checkPending = 1'b1;
        -> checkReq;
        wait (!checkPending);
    endtask

    task automatic multiplyAndCheck(input string label, input logic [7:0] b,
                                    input logic [7:0] s, output logic [16:0] prod);
        pressClearLoad(b);
        pressRun(s, pressLow);
        prod = refProduct(b, s);
        expectAndCheck($sformatf("%s %0d x %0d", label, $signed(b), $signed(s)), prod);
    endtask

    always begin : compareOutputs
        int wrong;
        @(checkReq);
        wrong = 0;
        if (Aval !== expA) begin
            $display("mismatch %s Aval expected %h actual %h", testName, expA, Aval);
            wrong++;
        end
        if (Bval !== expB) begin
            $display("mismatch %s Bval expected %h actual %h", testName, expB, Bval);
            wrong++;
        end
        if (Xval !== expX) begin
            $display("mismatch %s Xval expected %b actual %b", testName, expX, Xval);
            wrong++;
        end
        if (AHexU !== refSegments(expA[7:4])) begin
            $display("mismatch %s AHexU expected %b actual %b", testName,
                     refSegments(expA[7:4]), AHexU);
            wrong++;
        end
        if (AHexL !== refSegments(expA[3:0])) begin
            $display("mismatch %s AHexL expected %b actual %b", testName,
                     refSegments(expA[3:0]), AHexL);
            wrong++;
        end
        if (BHexU !== refSegments(expB[7:4])) begin
            $display("mismatch %s BHexU expected %b actual %b", testName,
                     refSegments(expB[7:4]), BHexU);
            wrong++;
        end
        if (BHexL !== refSegments(expB[3:0])) begin
            $display("mismatch %s BHexL expected %b actual %b", testName,
                     refSegments(expB[3:0]), BHexL);
            wrong++;
        end
        testCount++;
        if (wrong == 0) begin
            $display("ok      %s", testName);
        end
        else begin
            failCount++;
            $display("failed  %s with %0d wrong outputs", testName, wrong);
        end
        checkPending = 1'b0;
    end

    initial begin : watchdog
        repeat (timeoutCycles) @(posedge Clk);
        $display("run timed out after %0d cycles, controller in state %s",
                 timeoutCycles, u_multiplier8x8.control.state.name());
        $display(">>> FAIL");
        $finish;
    end

    initial begin : stimulus
        logic [dataWidth-1:0] b;
        logic [dataWidth-1:0] s;
        logic [16:0]          prod;
        Clk          = 1'b0;
        reset        = 1'b1;
        runN         = 1'b1;  // Buttons idle high
        clearLoadN   = 1'b1;
        S            = '0;
        rngState     = 32'h62c5_cfc1;
        checkPending = 1'b0;
        testCount    = 0;
        failCount    = 0;
        corners      = '{8'h00, 8'h01, 8'hFF, 8'h7F, 8'h80};
        repeat (3) @(posedge Clk);
        reset <= 1'b0;
        repeat (2) @(posedge Clk);  // Hex and X outputs lag one cycle
        expectAndCheck("after reset", 17'h0);

        // Product of -1 leaves A, B and X all ones before the clear-load
        multiplyAndCheck("negative", 8'hFF, 8'h01, prod);
        rngState = xorshift32(rngState);
        s = rngState[7:0];
        pressClearLoad(s);
        expectAndCheck($sformatf("clear-load S=%h", s), {9'h0, s});

        foreach (corners[i]) begin
            foreach (corners[j]) begin
                multiplyAndCheck("corner", corners[i], corners[j], prod);
            end
        end

        repeat (numRandom) begin
            rngState = xorshift32(rngState);
            multiplyAndCheck("random", rngState[7:0], rngState[15:8], prod);
        end

        // New runs reuse the low byte of the last product as multiplier
        rngState = xorshift32(rngState);
        multiplyAndCheck("chain base", rngState[7:0], rngState[15:8], prod);
        repeat (2) begin
            rngState = xorshift32(rngState);
            b = prod[7:0];
            s = rngState[7:0];
            pressRun(s, pressLow);
            prod = refProduct(b, s);
            expectAndCheck($sformatf("chained %0d x %0d", $signed(b), $signed(s)), prod);
        end

        // A second pass would give 15 x 5 instead of 15
        pressClearLoad(8'd3);
        pressRun(8'd5, holdLow);
        expectAndCheck("run held 60 cycles 3 x 5", refProduct(8'd3, 8'd5));

        $display("tests %0d, passed %0d, failed %0d", testCount, testCount - failCount,
                 failCount);
        if (failCount == 0) begin
            $display(">>> PASS");
        end
        else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* multiplier8x8.f */
multPkg.sv
inputSync.sv
shiftReg8.sv
addSub9.sv
multControl.sv
hexDriver.sv
multiplier8x8.sv
multiplier8x8_tb.sv

/* Makefile */
# Verilator simulation of the signed 8x8 multiplier

sim:
	verilator --binary --timing -Wno-fatal -f multiplier8x8.f \
		--top-module multiplier8x8_tb -o simv
	./obj_dir/simv > sim.log 2>&1; cat sim.log
	grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
